// ==== conv_csr_pkg.sv ====
`default_nettype none

package conv_csr_pkg;

	// Bus geometry
	localparam int CSR_DATA_WIDTH      = 32;
	localparam int CSR_ADDR_WIDTH      = 6;
	localparam int CSR_INDEX_BITS      = 4;
	localparam int CSR_ADDR_LSB        = 2;
	localparam int CSR_NUM_PARAM_WORDS = 9;

	// Register map, one 32-bit word per index
	typedef enum logic [CSR_INDEX_BITS-1:0] {
		CTRL           = 4'd0,
		KERNEL_BASE    = 4'd1,
		FEATURE_BASE   = 4'd2,
		FEATURE_WIDTH  = 4'd3,
		FEATURE_HEIGHT = 4'd4,
		FEATURE_CHIN   = 4'd5,
		FEATURE_CHOUT  = 4'd6,
		OUTPUT_BASE    = 4'd7,
		OUTPUT_WIDTH   = 4'd8,
		OUTPUT_HEIGHT  = 4'd9
	} csr_index_t;

	typedef logic [CSR_DATA_WIDTH-1:0] csr_word_t;
	typedef logic [7:0]                csr_byte_t;

	// ----------------------------------------
	// Control word layout
	// ----------------------------------------
	localparam int CTRL_START_BIT     = 0;
	localparam int CTRL_EXCEPTION_BIT = 1;
	localparam int CTRL_DONE_BIT      = 2;
	localparam int CTRL_RUNNING_BIT   = 3;
	// Bit 4 is reserved and reads zero
	localparam int CTRL_MODE_BIT      = 5;
	localparam int CTRL_RELU_BIT      = 6;
	localparam int CTRL_BIAS_BIT      = 7;
	localparam int CTRL_PAD_LSB       = 8;
	localparam int CTRL_STRIDE_LSB    = 16;
	localparam int CTRL_KSIZE_LSB     = 24;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== csr_wr_if.sv ====
`default_nettype none

interface csr_wr_if import conv_csr_pkg::*; #(
	parameter int DATA_WIDTH = CSR_DATA_WIDTH
) ();

	// One-cycle write strobe, no back-pressure
	logic                    wr_en;
	csr_index_t              wr_index;
	logic [DATA_WIDTH-1:0]   wr_data;
	logic [DATA_WIDTH/8-1:0] wr_strb;

	// Write channel side
	modport source (output wr_en, output wr_index, output wr_data, output wr_strb);

	// Register side, every sink decodes its own index
	modport sink (input wr_en, input wr_index, input wr_data, input wr_strb);

endinterface

`default_nettype wire

// ==== axi_lite_write_channel.sv ====
`default_nettype none

module axi_lite_write_channel import conv_csr_pkg::*; #(
	parameter int DATA_WIDTH = CSR_DATA_WIDTH,
	parameter int ADDR_WIDTH = CSR_ADDR_WIDTH
) (
	input  wire                    S_AXI_ACLK,
	input  wire                    S_AXI_ARESETN,
	input  wire [ADDR_WIDTH-1:0]   awaddr,
	input  wire                    awvalid,
	output logic                   awready,
	input  wire [DATA_WIDTH-1:0]   wdata,
	input  wire [DATA_WIDTH/8-1:0] wstrb,
	input  wire                    wvalid,
	output logic                   wready,
	output logic                   bvalid,
	output logic [1:0]             bresp,
	input  wire                    bready,
	csr_wr_if.source               wr
);

	typedef enum logic [1:0] {
		W_ADDR,
		W_DATA,
		W_RESP
	} wr_state_t;

	wr_state_t  state;
	csr_index_t aw_index;

	// ----------------------------------------
	// Handshake state machine
	// ----------------------------------------
	// At most one write in flight, B must complete before the next AW
	always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
		if (!S_AXI_ARESETN) begin
			state   <= W_ADDR;
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			case (state)
				W_ADDR: begin
					if (awvalid && awready) begin
						awready <= 1'b0;
						wready  <= 1'b1;
						state   <= W_DATA;
					end else begin
						// First edge out of reset opens the address channel
						awready <= 1'b1;
					end
				end
				W_DATA: begin
					if (wvalid) begin
						wready <= 1'b0;
						bvalid <= 1'b1;
						state  <= W_RESP;
					end
				end
				W_RESP: begin
					// Held-low bready stalls the next address here
					if (bready) begin
						bvalid  <= 1'b0;
						awready <= 1'b1;
						state   <= W_ADDR;
					end
				end
				default: begin
					state <= W_ADDR;
				end
			endcase
		end
	end

	// Word index of the accepted address
	always_ff @(posedge S_AXI_ACLK) begin
		if (awvalid && awready)
			aw_index <= csr_index_t'(awaddr[CSR_ADDR_LSB +: CSR_INDEX_BITS]);
	end

	// Register write fires in the W handshake cycle
	assign wr.wr_en    = wvalid && wready;
	assign wr.wr_index = aw_index;
	assign wr.wr_data  = wdata;
	assign wr.wr_strb  = wstrb;

	assign bresp = AXI_RESP_OKAY;

endmodule

`default_nettype wire

// ==== axi_lite_read_channel.sv ====
`default_nettype none

module axi_lite_read_channel import conv_csr_pkg::*; #(
	parameter int DATA_WIDTH = CSR_DATA_WIDTH,
	parameter int ADDR_WIDTH = CSR_ADDR_WIDTH
) (
	input  wire                                    S_AXI_ACLK,
	input  wire                                    S_AXI_ARESETN,
	input  wire [ADDR_WIDTH-1:0]                   araddr,
	input  wire                                    arvalid,
	output logic                                   arready,
	output logic                                   rvalid,
	output logic [1:0]                             rresp,
	output logic [DATA_WIDTH-1:0]                  rdata,
	input  wire                                    rready,
	input  csr_word_t                              ctrl_word,
	input  csr_word_t [CSR_NUM_PARAM_WORDS:1]      param_words
);

	typedef enum logic {
		R_ADDR,
		R_DATA
	} rd_state_t;

	rd_state_t  state;
	csr_index_t rd_index;

	// ----------------------------------------
	// Read handshake
	// ----------------------------------------
	always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
		if (!S_AXI_ARESETN) begin
			state   <= R_ADDR;
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			case (state)
				R_ADDR: begin
					if (arvalid && arready) begin
						arready <= 1'b0;
						rvalid  <= 1'b1;
						state   <= R_DATA;
					end else begin
						// Also reopens one edge after each R handshake
						arready <= 1'b1;
					end
				end
				R_DATA: begin
					if (rready) begin
						rvalid <= 1'b0;
						state  <= R_ADDR;
					end
				end
				default: begin
					state <= R_ADDR;
				end
			endcase
		end
	end

	// Index held for the whole data phase
	always_ff @(posedge S_AXI_ACLK) begin
		if (arvalid && arready)
			rd_index <= csr_index_t'(araddr[CSR_ADDR_LSB +: CSR_INDEX_BITS]);
	end

	// Read mux straight from live registers, unmapped indices give zero
	always_comb begin
		rdata = '0;
		if (rd_index == CTRL)
			rdata = ctrl_word;
		for (int i = 1; i <= CSR_NUM_PARAM_WORDS; i++) begin
			if (rd_index == i)
				rdata = param_words[i];
		end
	end

	assign rresp = AXI_RESP_OKAY;

endmodule

`default_nettype wire

// ==== conv_ctrl_reg.sv ====
`default_nettype none

module conv_ctrl_reg import conv_csr_pkg::*; (
	input  wire       S_AXI_ACLK,
	input  wire       S_AXI_ARESETN,
	csr_wr_if.sink    wr,
	input  wire       running,
	input  wire       compute_done,
	input  wire       exception,
	output csr_byte_t kernel_size,
	output csr_byte_t stride,
	output csr_byte_t padding,
	output logic      has_bias,
	output logic      has_relu,
	output logic      conv_mode,
	output logic      start,
	output csr_word_t ctrl_word
);

	localparam int FIELD_BITS = $bits(csr_byte_t);

	logic ctrl_hit;
	logic running_q;
	logic done_q;
	logic exception_q;

	assign ctrl_hit = wr.wr_en && (wr.wr_index == CTRL);

	// ----------------------------------------
	// Writable fields and start pulse
	// ----------------------------------------
	// Whole word loads at once, byte strobes ignored for CTRL
	always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
		if (!S_AXI_ARESETN) begin
			kernel_size <= '0;
			stride      <= '0;
			padding     <= '0;
			has_bias    <= 1'b0;
			has_relu    <= 1'b0;
			conv_mode   <= 1'b0;
			start       <= 1'b0;
		end else if (ctrl_hit) begin
			kernel_size <= wr.wr_data[CTRL_KSIZE_LSB +: FIELD_BITS];
			stride      <= wr.wr_data[CTRL_STRIDE_LSB +: FIELD_BITS];
			padding     <= wr.wr_data[CTRL_PAD_LSB +: FIELD_BITS];
			has_bias    <= wr.wr_data[CTRL_BIAS_BIT];
			has_relu    <= wr.wr_data[CTRL_RELU_BIT];
			conv_mode   <= wr.wr_data[CTRL_MODE_BIT];
			start       <= wr.wr_data[CTRL_START_BIT];
		end else begin
			// Self-clearing, high for one cycle only
			start <= 1'b0;
		end
	end

	// ----------------------------------------
	// Status capture
	// ----------------------------------------
	always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
		if (!S_AXI_ARESETN) begin
			running_q   <= 1'b0;
			done_q      <= 1'b0;
			exception_q <= 1'b0;
		end else begin
			// Plain sample every cycle
			running_q <= running;
			// Sticky once set, start re-arms
			if (!done_q || start)
				done_q <= compute_done;
			if (!exception_q || start)
				exception_q <= exception;
		end
	end

	// Packed view for read-back
	always_comb begin
		ctrl_word                                  = '0;
		ctrl_word[CTRL_START_BIT]                  = start;
		ctrl_word[CTRL_EXCEPTION_BIT]              = exception_q;
		ctrl_word[CTRL_DONE_BIT]                   = done_q;
		ctrl_word[CTRL_RUNNING_BIT]                = running_q;
		ctrl_word[CTRL_MODE_BIT]                   = conv_mode;
		ctrl_word[CTRL_RELU_BIT]                   = has_relu;
		ctrl_word[CTRL_BIAS_BIT]                   = has_bias;
		ctrl_word[CTRL_PAD_LSB +: FIELD_BITS]      = padding;
		ctrl_word[CTRL_STRIDE_LSB +: FIELD_BITS]   = stride;
		ctrl_word[CTRL_KSIZE_LSB +: FIELD_BITS]    = kernel_size;
	end

endmodule

`default_nettype wire

// ==== csr_word.sv ====
`default_nettype none

module csr_word import conv_csr_pkg::*; #(
	parameter csr_index_t WORD_INDEX = KERNEL_BASE,
	parameter int         DATA_WIDTH = CSR_DATA_WIDTH
) (
	input  wire       S_AXI_ACLK,
	input  wire       S_AXI_ARESETN,
	csr_wr_if.sink    wr,
	output csr_word_t value
);

	logic hit;

	// Own index decode
	assign hit = wr.wr_en && (wr.wr_index == WORD_INDEX);

	// Byte lanes merge under the write strobes
	always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
		if (!S_AXI_ARESETN) begin
			value <= '0;
		end else if (hit) begin
			for (int b = 0; b < DATA_WIDTH/8; b++) begin
				if (wr.wr_strb[b])
					value[b*8 +: 8] <= wr.wr_data[b*8 +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// ==== conv_csr_top.sv ====
`default_nettype none

module conv_csr_top import conv_csr_pkg::*; #(
	parameter int DATA_WIDTH = CSR_DATA_WIDTH,
	parameter int ADDR_WIDTH = CSR_ADDR_WIDTH
) (
	input  wire                    S_AXI_ACLK,
	input  wire                    S_AXI_ARESETN,
	// AXI4-Lite slave
	input  wire [ADDR_WIDTH-1:0]   s_axi_awaddr,
	input  wire                    s_axi_awvalid,
	output logic                   s_axi_awready,
	input  wire [DATA_WIDTH-1:0]   s_axi_wdata,
	input  wire [DATA_WIDTH/8-1:0] s_axi_wstrb,
	input  wire                    s_axi_wvalid,
	output logic                   s_axi_wready,
	output logic [1:0]             s_axi_bresp,
	output logic                   s_axi_bvalid,
	input  wire                    s_axi_bready,
	input  wire [ADDR_WIDTH-1:0]   s_axi_araddr,
	input  wire                    s_axi_arvalid,
	output logic                   s_axi_arready,
	output logic [DATA_WIDTH-1:0]  s_axi_rdata,
	output logic [1:0]             s_axi_rresp,
	output logic                   s_axi_rvalid,
	input  wire                    s_axi_rready,
	// Accelerator control
	output csr_byte_t              kernel_size,
	output csr_byte_t              stride,
	output csr_byte_t              padding,
	output logic                   has_bias,
	output logic                   has_relu,
	output logic                   conv_mode,
	output logic                   start,
	output csr_word_t              kernel_baseaddr,
	output csr_word_t              feature_baseaddr,
	output csr_word_t              feature_width,
	output csr_word_t              feature_height,
	output csr_word_t              feature_chin,
	output csr_word_t              feature_chout,
	output csr_word_t              output_baseaddr,
	output csr_word_t              output_width,
	output csr_word_t              output_height,
	// Accelerator status
	input  wire                    running,
	input  wire                    compute_done,
	input  wire                    exception
);

	csr_word_t                         ctrl_word;
	csr_word_t [CSR_NUM_PARAM_WORDS:1] param_words;

	csr_wr_if #(.DATA_WIDTH(DATA_WIDTH)) wr_bus ();

	axi_lite_write_channel #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_wr_ch (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.awaddr       (s_axi_awaddr),
		.awvalid      (s_axi_awvalid),
		.awready      (s_axi_awready),
		.wdata        (s_axi_wdata),
		.wstrb        (s_axi_wstrb),
		.wvalid       (s_axi_wvalid),
		.wready       (s_axi_wready),
		.bvalid       (s_axi_bvalid),
		.bresp        (s_axi_bresp),
		.bready       (s_axi_bready),
		.wr           (wr_bus)
	);

	// Index 0 lives apart from the strobed words
	conv_ctrl_reg u_ctrl (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.wr           (wr_bus),
		.running      (running),
		.compute_done (compute_done),
		.exception    (exception),
		.kernel_size  (kernel_size),
		.stride       (stride),
		.padding      (padding),
		.has_bias     (has_bias),
		.has_relu     (has_relu),
		.conv_mode    (conv_mode),
		.start        (start),
		.ctrl_word    (ctrl_word)
	);

	// ----------------------------------------
	// Parameter words, indices 1 to 9
	// ----------------------------------------
	for (genvar i = 1; i <= CSR_NUM_PARAM_WORDS; i++) begin : g_param
		csr_word #(
			.WORD_INDEX(csr_index_t'(i)),
			.DATA_WIDTH(DATA_WIDTH)
		) u_word (
			.S_AXI_ACLK   (S_AXI_ACLK),
			.S_AXI_ARESETN(S_AXI_ARESETN),
			.wr           (wr_bus),
			.value        (param_words[i])
		);
	end

	assign kernel_baseaddr  = param_words[KERNEL_BASE];
	assign feature_baseaddr = param_words[FEATURE_BASE];
	assign feature_width    = param_words[FEATURE_WIDTH];
	assign feature_height   = param_words[FEATURE_HEIGHT];
	assign feature_chin     = param_words[FEATURE_CHIN];
	assign feature_chout    = param_words[FEATURE_CHOUT];
	assign output_baseaddr  = param_words[OUTPUT_BASE];
	assign output_width     = param_words[OUTPUT_WIDTH];
	assign output_height    = param_words[OUTPUT_HEIGHT];

	axi_lite_read_channel #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_rd_ch (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.araddr       (s_axi_araddr),
		.arvalid      (s_axi_arvalid),
		.arready      (s_axi_arready),
		.rvalid       (s_axi_rvalid),
		.rresp        (s_axi_rresp),
		.rdata        (s_axi_rdata),
		.rready       (s_axi_rready),
		.ctrl_word    (ctrl_word),
		.param_words  (param_words)
	);

endmodule

`default_nettype wire

// ==== tb_conv_csr.sv ====
`default_nettype none

module tb_conv_csr import conv_csr_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DATA_WIDTH   = CSR_DATA_WIDTH;
	localparam int ADDR_WIDTH   = CSR_ADDR_WIDTH;
	localparam int RESET_CYCLES = 8;
	localparam int HS_LIMIT     = 16;
	localparam int STALL_CYCLES = 5;
	// 18 + 18 + 2 + 5 + 19 bus transactions over the five tests
	localparam int NUM_TXN      = 62;
	localparam int CYCLE_LIMIT  = 40 * NUM_TXN + RESET_CYCLES;

	logic                    S_AXI_ACLK;
	logic                    S_AXI_ARESETN;
	logic [ADDR_WIDTH-1:0]   s_axi_awaddr;
	logic                    s_axi_awvalid;
	logic                    s_axi_awready;
	logic [DATA_WIDTH-1:0]   s_axi_wdata;
	logic [DATA_WIDTH/8-1:0] s_axi_wstrb;
	logic                    s_axi_wvalid;
	logic                    s_axi_wready;
	logic [1:0]              s_axi_bresp;
	logic                    s_axi_bvalid;
	logic                    s_axi_bready;
	logic [ADDR_WIDTH-1:0]   s_axi_araddr;
	logic                    s_axi_arvalid;
	logic                    s_axi_arready;
	logic [DATA_WIDTH-1:0]   s_axi_rdata;
	logic [1:0]              s_axi_rresp;
	logic                    s_axi_rvalid;
	logic                    s_axi_rready;
	csr_byte_t               kernel_size;
	csr_byte_t               stride;
	csr_byte_t               padding;
	logic                    has_bias;
	logic                    has_relu;
	logic                    conv_mode;
	logic                    start;
	csr_word_t               kernel_baseaddr;
	csr_word_t               feature_baseaddr;
	csr_word_t               feature_width;
	csr_word_t               feature_height;
	csr_word_t               feature_chin;
	csr_word_t               feature_chout;
	csr_word_t               output_baseaddr;
	csr_word_t               output_width;
	csr_word_t               output_height;
	logic                    running;
	logic                    compute_done;
	logic                    exception;

	// Reference model state
	csr_word_t shadow [0:15];
	csr_byte_t m_ksize;
	csr_byte_t m_stride;
	csr_byte_t m_pad;
	logic      m_bias;
	logic      m_relu;
	logic      m_mode;
	logic      m_running;
	logic      m_done;
	logic      m_exc;

	// Pending comparisons for the compare process
	string     word_name_q [$];
	csr_word_t word_exp_q  [$];
	csr_word_t word_act_q  [$];
	string     bit_name_q  [$];
	logic      bit_exp_q   [$];
	logic      bit_act_q   [$];

	int        word_errors;
	int        bit_errors;
	int        hs_errors;
	int        cycle_count;
	logic [31:0] rng;

	conv_csr_top #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH)
	) dut0 (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.S_AXI_ARESETN   (S_AXI_ARESETN),
		.s_axi_awaddr    (s_axi_awaddr),
		.s_axi_awvalid   (s_axi_awvalid),
		.s_axi_awready   (s_axi_awready),
		.s_axi_wdata     (s_axi_wdata),
		.s_axi_wstrb     (s_axi_wstrb),
		.s_axi_wvalid    (s_axi_wvalid),
		.s_axi_wready    (s_axi_wready),
		.s_axi_bresp     (s_axi_bresp),
		.s_axi_bvalid    (s_axi_bvalid),
		.s_axi_bready    (s_axi_bready),
		.s_axi_araddr    (s_axi_araddr),
		.s_axi_arvalid   (s_axi_arvalid),
		.s_axi_arready   (s_axi_arready),
		.s_axi_rdata     (s_axi_rdata),
		.s_axi_rresp     (s_axi_rresp),
		.s_axi_rvalid    (s_axi_rvalid),
		.s_axi_rready    (s_axi_rready),
		.kernel_size     (kernel_size),
		.stride          (stride),
		.padding         (padding),
		.has_bias        (has_bias),
		.has_relu        (has_relu),
		.conv_mode       (conv_mode),
		.start           (start),
		.kernel_baseaddr (kernel_baseaddr),
		.feature_baseaddr(feature_baseaddr),
		.feature_width   (feature_width),
		.feature_height  (feature_height),
		.feature_chin    (feature_chin),
		.feature_chout   (feature_chout),
		.output_baseaddr (output_baseaddr),
		.output_width    (output_width),
		.output_height   (output_height),
		.running         (running),
		.compute_done    (compute_done),
		.exception       (exception)
	);

	// 20 ns clock
	initial begin
		S_AXI_ACLK = 1'b0;
		forever #10 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Byte lanes with strobe set take the new data
	function automatic csr_word_t merge_bytes(input csr_word_t old, input csr_word_t data,
			input logic [3:0] strb);
		csr_word_t w;
		w = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				w[b*8 +: 8] = data[b*8 +: 8];
		end
		return w;
	endfunction

	// Start and reserved bit 4 read back clear
	function automatic csr_word_t pack_ctrl();
		csr_word_t w;
		w = '0;
		w[CTRL_KSIZE_LSB +: 8]  = m_ksize;
		w[CTRL_STRIDE_LSB +: 8] = m_stride;
		w[CTRL_PAD_LSB +: 8]    = m_pad;
		w[CTRL_BIAS_BIT]        = m_bias;
		w[CTRL_RELU_BIT]        = m_relu;
		w[CTRL_MODE_BIT]        = m_mode;
		w[CTRL_RUNNING_BIT]     = m_running;
		w[CTRL_DONE_BIT]        = m_done;
		w[CTRL_EXCEPTION_BIT]   = m_exc;
		return w;
	endfunction

	function automatic csr_word_t expected_read(input int idx);
		if (idx == 0)
			return pack_ctrl();
		if (idx <= CSR_NUM_PARAM_WORDS)
			return shadow[idx];
		return '0;
	endfunction

	// CTRL loads all fields and ignores strobes
	// Unmapped writes vanish
	task automatic model_write(input int idx, input csr_word_t data, input logic [3:0] strb);
		if (idx == 0) begin
			m_ksize  = data[CTRL_KSIZE_LSB +: 8];
			m_stride = data[CTRL_STRIDE_LSB +: 8];
			m_pad    = data[CTRL_PAD_LSB +: 8];
			m_bias   = data[CTRL_BIAS_BIT];
			m_relu   = data[CTRL_RELU_BIT];
			m_mode   = data[CTRL_MODE_BIT];
		end else if (idx <= CSR_NUM_PARAM_WORDS) begin
			shadow[idx] = merge_bytes(shadow[idx], data, strb);
		end
	endtask

	// Named output port for a parameter index
	function automatic csr_word_t port_value(input int idx);
		case (idx)
			1:       return kernel_baseaddr;
			2:       return feature_baseaddr;
			3:       return feature_width;
			4:       return feature_height;
			5:       return feature_chin;
			6:       return feature_chout;
			7:       return output_baseaddr;
			8:       return output_width;
			9:       return output_height;
			default: return '0;
		endcase
	endfunction

	// ----------------------------------------
	// Checking
	// ----------------------------------------
	task automatic expect_word(input string name, input csr_word_t exp, input csr_word_t act);
		word_name_q.push_back(name);
		word_exp_q.push_back(exp);
		word_act_q.push_back(act);
	endtask

	task automatic expect_bit(input string name, input logic exp, input logic act);
		bit_name_q.push_back(name);
		bit_exp_q.push_back(exp);
		bit_act_q.push_back(act);
	endtask

	task automatic check_word(input string name, input csr_word_t exp, input csr_word_t act);
		if (act !== exp) begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			word_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error %s: expected %b, actual %b", name, exp, act);
			bit_errors++;
		end
	endtask

	task automatic report_missing(input string name, input string what);
		$display("%s: no %s from the DUT within %0d cycles", name, what, HS_LIMIT);
		hs_errors++;
	endtask

	// Compare process
	always @(posedge S_AXI_ACLK) begin
		while (word_act_q.size() > 0)
			check_word(word_name_q.pop_front(), word_exp_q.pop_front(), word_act_q.pop_front());
		while (bit_act_q.size() > 0)
			check_bit(bit_name_q.pop_front(), bit_exp_q.pop_front(), bit_act_q.pop_front());
	end

	// ----------------------------------------
	// AXI4-Lite master
	// ----------------------------------------
	// Inputs change and ready/valid are sampled on the falling edge
	task automatic axi_write(input string name, input int idx, input csr_word_t data,
			input logic [3:0] strb, input int b_stall);
		int   waited;
		logic exp_start;
		exp_start = (idx == 0) && data[CTRL_START_BIT];
		@(negedge S_AXI_ACLK);
		s_axi_awaddr  = ADDR_WIDTH'(idx * 4);
		s_axi_awvalid = 1'b1;
		s_axi_wdata   = data;
		s_axi_wstrb   = strb;
		s_axi_wvalid  = 1'b1;
		waited = 0;
		while (!s_axi_awready && waited < HS_LIMIT) begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!s_axi_awready)
			report_missing(name, "AWREADY");
		// AW handshake on the coming edge
		@(negedge S_AXI_ACLK);
		s_axi_awvalid = 1'b0;
		waited = 0;
		while (!s_axi_wready && waited < HS_LIMIT) begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!s_axi_wready)
			report_missing(name, "WREADY");
		@(negedge S_AXI_ACLK);
		s_axi_wvalid = 1'b0;
		// Register visible one edge after W
		model_write(idx, data, strb);
		expect_bit({name, " start"}, exp_start, start);
		if (idx >= 1 && idx <= CSR_NUM_PARAM_WORDS)
			expect_word({name, " port"}, shadow[idx], port_value(idx));
		@(negedge S_AXI_ACLK);
		expect_bit({name, " start clear"}, 1'b0, start);
		waited = 0;
		while (!s_axi_bvalid && waited < HS_LIMIT) begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!s_axi_bvalid)
			report_missing(name, "BVALID");
		expect_word({name, " bresp"}, csr_word_t'(AXI_RESP_OKAY), csr_word_t'(s_axi_bresp));
		// Held-off BREADY must block the address channel
		repeat (b_stall) begin
			expect_bit({name, " awready in B stall"}, 1'b0, s_axi_awready);
			@(negedge S_AXI_ACLK);
		end
		s_axi_bready = 1'b1;
		@(negedge S_AXI_ACLK);
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input string name, input int idx, input int r_stall);
		int waited;
		@(negedge S_AXI_ACLK);
		s_axi_araddr  = ADDR_WIDTH'(idx * 4);
		s_axi_arvalid = 1'b1;
		waited = 0;
		while (!s_axi_arready && waited < HS_LIMIT) begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!s_axi_arready)
			report_missing(name, "ARREADY");
		@(negedge S_AXI_ACLK);
		s_axi_arvalid = 1'b0;
		waited = 0;
		while (!s_axi_rvalid && waited < HS_LIMIT) begin
			@(negedge S_AXI_ACLK);
			waited++;
		end
		if (!s_axi_rvalid)
			report_missing(name, "RVALID");
		expect_word({name, " rdata"}, expected_read(idx), s_axi_rdata);
		expect_word({name, " rresp"}, csr_word_t'(AXI_RESP_OKAY), csr_word_t'(s_axi_rresp));
		// The latched index holds RDATA while the idle AR address moves
		s_axi_araddr = ADDR_WIDTH'(((idx + 1) % 16) * 4);
		// RDATA and RVALID hold while RREADY is low
		repeat (r_stall) begin
			@(negedge S_AXI_ACLK);
			expect_bit({name, " rvalid held"}, 1'b1, s_axi_rvalid);
			expect_word({name, " rdata held"}, expected_read(idx), s_axi_rdata);
		end
		s_axi_rready = 1'b1;
		@(negedge S_AXI_ACLK);
		s_axi_rready = 1'b0;
	endtask

	task automatic check_ctrl_ports(input string name);
		expect_word({name, " kernel_size"}, csr_word_t'(m_ksize), csr_word_t'(kernel_size));
		expect_word({name, " stride"}, csr_word_t'(m_stride), csr_word_t'(stride));
		expect_word({name, " padding"}, csr_word_t'(m_pad), csr_word_t'(padding));
		expect_bit({name, " has_bias"}, m_bias, has_bias);
		expect_bit({name, " has_relu"}, m_relu, has_relu);
		expect_bit({name, " conv_mode"}, m_mode, conv_mode);
	endtask

	// Watchdog
	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge S_AXI_ACLK);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("RESULT: FAIL");
		$finish;
	end

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	initial begin : main
		csr_word_t  data;
		logic [3:0] strb;
		int         total;
		S_AXI_ARESETN = 1'b0;
		s_axi_awaddr  = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wstrb   = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b0;
		s_axi_araddr  = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b0;
		running       = 1'b0;
		compute_done  = 1'b0;
		exception     = 1'b0;
		word_errors   = 0;
		bit_errors    = 0;
		hs_errors     = 0;
		rng           = 32'h0f02_6b53;
		for (int i = 0; i < 16; i++)
			shadow[i] = '0;
		{m_ksize, m_stride, m_pad} = '0;
		{m_bias, m_relu, m_mode, m_running, m_done, m_exc} = '0;
		repeat (RESET_CYCLES) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;

		// Full-strobe writes followed by read-back and every named port
		for (int i = 1; i <= CSR_NUM_PARAM_WORDS; i++) begin
			rng = xorshift32(rng);
			axi_write("full write", i, rng, 4'hf, 0);
		end
		for (int i = 1; i <= CSR_NUM_PARAM_WORDS; i++) begin
			axi_read("full readback", i, 0);
			expect_word("full port", shadow[i], port_value(i));
		end

		// Untouched lanes keep their old bytes under random strobes
		for (int i = 1; i <= CSR_NUM_PARAM_WORDS; i++) begin
			rng = xorshift32(rng);
			strb = rng[3:0];
			rng = xorshift32(rng);
			axi_write("strobe write", i, rng, strb, 0);
			axi_read("strobe readback", i, 0);
		end

		// Control word fields and the start pulse
		rng = xorshift32(rng);
		data = rng;
		data[CTRL_START_BIT] = 1'b1;
		axi_write("ctrl write", 0, data, 4'hf, 0);
		check_ctrl_ports("ctrl write");
		axi_read("ctrl readback", 0, 0);

		// Running is sampled
		running = 1'b1;
		m_running = 1'b1;
		repeat (2) @(negedge S_AXI_ACLK);
		axi_read("running held", 0, 0);
		running = 1'b0;
		m_running = 1'b0;
		// Done and exception stick after a one-cycle pulse
		compute_done = 1'b1;
		@(negedge S_AXI_ACLK);
		compute_done = 1'b0;
		m_done = 1'b1;
		axi_read("done sticky", 0, 0);
		exception = 1'b1;
		@(negedge S_AXI_ACLK);
		exception = 1'b0;
		m_exc = 1'b1;
		axi_read("exception sticky", 0, 0);
		// Start with both inputs low re-arms the flags
		rng = xorshift32(rng);
		data = rng;
		data[CTRL_START_BIT] = 1'b1;
		axi_write("rearm write", 0, data, 4'hf, 0);
		m_done = 1'b0;
		m_exc = 1'b0;
		check_ctrl_ports("rearm write");
		axi_read("rearm readback", 0, 0);

		// Unmapped reads followed by both stalls
		for (int i = CSR_NUM_PARAM_WORDS + 1; i < 16; i++)
			axi_read("unmapped read", i, 0);
		axi_read("rready stall", FEATURE_CHIN, STALL_CYCLES);
		rng = xorshift32(rng);
		axi_write("bready stall", OUTPUT_WIDTH, rng, 4'hf, STALL_CYCLES);
		// Write to index 12 must leave the map alone
		rng = xorshift32(rng);
		axi_write("unmapped write", 12, rng, 4'hf, 0);
		for (int i = 0; i <= CSR_NUM_PARAM_WORDS; i++)
			axi_read("after unmapped write", i, 0);

		// Let the compare process drain
		@(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		total = word_errors + bit_errors + hs_errors;
		$display("errors: %0d word mismatches, %0d bit mismatches, %0d handshake failures",
			word_errors, bit_errors, hs_errors);
		if (total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
conv_csr_pkg.sv
csr_wr_if.sv
axi_lite_write_channel.sv
axi_lite_read_channel.sv
conv_ctrl_reg.sv
csr_word.sv
conv_csr_top.sv
tb_conv_csr.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CSR block testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_conv_csr -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/Vtb_conv_csr > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
	exit 1
fi
exit 0
